// ==== hw/mm_pkg.sv ====
// memory-mapped ram wrapper definitions
`default_nettype none

package mm_pkg;

    // ram geometry
    localparam int unsigned ram_addr_width = 16;
    localparam int unsigned ram_bytes      = 65536;

    // plain vector types
    typedef logic [31:0]               word_t;
    typedef logic [3:0]                be_t;
    typedef logic [ram_addr_width-1:0] ram_addr_t;
    typedef logic [127:0]              instr_data_t;
    typedef logic [4:0]                irq_id_t;

    // data port address map
    localparam word_t addr_timer_mask  = 32'h1500_0000;
    localparam word_t addr_timer_cnt   = 32'h1500_0004;
    localparam word_t addr_test_status = 32'h2000_0000;
    localparam word_t addr_exit        = 32'h2000_0004;

    // values written to the status register by the test program
    localparam word_t test_pass_value = 32'd123456789;
    localparam word_t test_fail_value = 32'd1;

    // mask bit and acknowledge id of the timer interrupt
    localparam int unsigned timer_irq_id = 7;

    // where the read data of a data access comes from
    typedef enum logic [1:0] {
        tgt_ram,
        tgt_timer_cnt,
        tgt_none
    } target_e;

endpackage

`default_nettype wire

// ==== hw/dp_ram.sv ====
// dual-port ram
`timescale 1ns/1ps
`default_nettype none

module dp_ram import mm_pkg::*; (
    input  wire logic        clk_i,

    input  wire logic        instr_en_i,
    input  wire ram_addr_t   instr_addr_i,
    output instr_data_t      instr_rdata_o,

    input  wire logic        data_en_i,
    input  wire logic        data_we_i,
    input  wire be_t         data_be_i,
    input  wire ram_addr_t   data_addr_i,
    input  wire word_t       data_wdata_i,
    output word_t            data_rdata_o
);

    logic [7:0] mem [ram_bytes];

    ram_addr_t instr_base;
    ram_addr_t data_base;

    // both ports work on whole words
    assign instr_base = {instr_addr_i[ram_addr_width-1:2], 2'b00};
    assign data_base  = {data_addr_i[ram_addr_width-1:2], 2'b00};

    // one process so a same-cycle fetch sees the old contents
    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            // four words lowest first and wrapping at the top of the ram
            for (int w = 0; w < 4; w++) begin
                for (int b = 0; b < 4; b++) begin
                    instr_rdata_o[32*w + 8*b +: 8] <=
                        mem[ram_addr_t'(instr_base + ram_addr_t'(4*w + b))];
                end
            end
        end

        if (data_en_i) begin
            if (data_we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_be_i[b]) begin
                        mem[data_base + ram_addr_t'(b)] <= data_wdata_i[8*b +: 8];
                    end
                end
            end else begin
                for (int b = 0; b < 4; b++) begin
                    data_rdata_o[8*b +: 8] <= mem[data_base + ram_addr_t'(b)];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/data_decoder.sv ====
// data port address decoder
`timescale 1ns/1ps
`default_nettype none

module data_decoder import mm_pkg::*; (
    input  wire logic   data_req_i,
    input  wire logic   data_we_i,
    input  wire word_t  data_addr_i,
    input  wire be_t    data_be_i,
    input  wire word_t  data_wdata_i,

    // ram side
    output logic        ram_en_o,
    output logic        ram_we_o,
    output ram_addr_t   ram_addr_o,
    output be_t         ram_be_o,
    output word_t       ram_wdata_o,

    // timer registers
    output logic        timer_mask_we_o,
    output logic        timer_cnt_we_o,
    output word_t       timer_wdata_o,

    // read data source for the response
    output target_e     rd_target_o,

    // test status
    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic        exit_valid_o,
    output word_t       exit_value_o
);

    logic is_ram;

    assign is_ram = (data_addr_i < ram_bytes);

    // payload goes out unqualified and the enables select the target
    assign ram_addr_o    = data_addr_i[ram_addr_width-1:0];
    assign ram_be_o      = data_be_i;
    assign ram_wdata_o   = data_wdata_i;
    assign timer_wdata_o = data_wdata_i;

    always_comb begin
        ram_en_o        = 1'b0;
        ram_we_o        = 1'b0;
        timer_mask_we_o = 1'b0;
        timer_cnt_we_o  = 1'b0;
        rd_target_o     = tgt_none;
        tests_passed_o  = 1'b0;
        tests_failed_o  = 1'b0;
        exit_valid_o    = 1'b0;
        exit_value_o    = '0;

        if (data_req_i) begin
            if (is_ram) begin
                ram_en_o = 1'b1;
                ram_we_o = data_we_i;
                if (!data_we_i) begin
                    rd_target_o = tgt_ram;
                end
            end else if (data_we_i) begin
                // unmapped writes fall through and are dropped
                if (data_addr_i == addr_timer_mask) begin
                    timer_mask_we_o = 1'b1;
                end else if (data_addr_i == addr_timer_cnt) begin
                    timer_cnt_we_o = 1'b1;
                end else if (data_addr_i == addr_test_status) begin
                    tests_passed_o = (data_wdata_i == test_pass_value);
                    tests_failed_o = (data_wdata_i == test_fail_value);
                end else if (data_addr_i == addr_exit) begin
                    exit_valid_o = 1'b1;
                    exit_value_o = data_wdata_i;
                end
            end else if (data_addr_i == addr_timer_cnt) begin
                rd_target_o = tgt_timer_cnt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/data_resp_ctrl.sv ====
// data port response control
`timescale 1ns/1ps
`default_nettype none

module data_resp_ctrl import mm_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,

    input  wire logic     data_req_i,
    input  wire target_e  rd_target_i,
    input  wire word_t    ram_rdata_i,
    input  wire word_t    timer_cnt_i,

    output logic          data_rvalid_o,
    output word_t         data_rdata_o
);

    logic    rvalid_q;
    target_e target_q;
    word_t   cnt_q;

    // every request is granted at once, so valid is just the request delayed
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            target_q <= tgt_none;
        end else begin
            rvalid_q <= data_req_i;
            target_q <= rd_target_i;
        end
    end

    // count as it stood in the request cycle
    always_ff @(posedge clk_i) begin
        if (data_req_i && (rd_target_i == tgt_timer_cnt)) begin
            cnt_q <= timer_cnt_i;
        end
    end

    assign data_rvalid_o = rvalid_q;

    always_comb begin
        case (target_q)
            tgt_ram:       data_rdata_o = ram_rdata_i;
            tgt_timer_cnt: data_rdata_o = cnt_q;
            default:       data_rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/sim_timer.sv ====
// countdown timer with interrupt
`timescale 1ns/1ps
`default_nettype none

module sim_timer import mm_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,

    input  wire logic     mask_we_i,
    input  wire logic     cnt_we_i,
    input  wire word_t    wdata_i,

    input  wire logic     irq_ack_i,
    input  wire irq_id_t  irq_id_i,

    output word_t         cnt_o,
    output logic          irq_timer_o
);

    word_t mask_q;
    word_t cnt_q;
    logic  irq_q;
    logic  reg_write;
    logic  ack_match;

    assign reg_write = mask_we_i || cnt_we_i;
    assign ack_match = irq_ack_i && (irq_id_i == irq_id_t'(timer_irq_id));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= 1'b0;
        end else if (reg_write) begin
            // a write cycle freezes the count
            if (mask_we_i) begin
                mask_q <= wdata_i;
            end
            if (cnt_we_i) begin
                cnt_q <= wdata_i;
            end
        end else begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            // fires on the step from one to zero
            if ((cnt_q == 32'd1) && mask_q[timer_irq_id]) begin
                irq_q <= 1'b1;
            end
            // ack has priority over a new set
            if (ack_match) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign cnt_o       = cnt_q;
    assign irq_timer_o = irq_q;

endmodule

`default_nettype wire

// ==== hw/mm_ram.sv ====
// memory-mapped ram wrapper top level
`timescale 1ns/1ps
`default_nettype none

module mm_ram import mm_pkg::*; (
    input  wire logic         clk_i,
    input  wire logic         rst_ni,

    // instruction fetch port
    input  wire logic         instr_req_i,
    input  wire ram_addr_t    instr_addr_i,
    output instr_data_t       instr_rdata_o,
    output logic              instr_rvalid_o,
    output logic              instr_gnt_o,

    // data port
    input  wire logic         data_req_i,
    input  wire word_t        data_addr_i,
    input  wire logic         data_we_i,
    input  wire be_t          data_be_i,
    input  wire word_t        data_wdata_i,
    output word_t             data_rdata_o,
    output logic              data_rvalid_o,
    output logic              data_gnt_o,

    // interrupt
    input  wire irq_id_t      irq_id_i,
    input  wire logic         irq_ack_i,
    output logic              irq_timer_o,

    // test status
    output logic              tests_passed_o,
    output logic              tests_failed_o,
    output logic              exit_valid_o,
    output word_t             exit_value_o
);

    logic      instr_rvalid_q;

    logic      ram_en;
    logic      ram_we;
    ram_addr_t ram_addr;
    be_t       ram_be;
    word_t     ram_wdata;
    word_t     ram_rdata;

    logic      timer_mask_we;
    logic      timer_cnt_we;
    word_t     timer_wdata;
    word_t     timer_cnt;

    target_e   rd_target;

    // ram never stalls, so grant follows request
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_q <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i;
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;

    data_decoder data_decoder_inst (
        .data_req_i      (data_req_i),
        .data_we_i       (data_we_i),
        .data_addr_i     (data_addr_i),
        .data_be_i       (data_be_i),
        .data_wdata_i    (data_wdata_i),
        .ram_en_o        (ram_en),
        .ram_we_o        (ram_we),
        .ram_addr_o      (ram_addr),
        .ram_be_o        (ram_be),
        .ram_wdata_o     (ram_wdata),
        .timer_mask_we_o (timer_mask_we),
        .timer_cnt_we_o  (timer_cnt_we),
        .timer_wdata_o   (timer_wdata),
        .rd_target_o     (rd_target),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o)
    );

    dp_ram dp_ram_inst (
        .clk_i         (clk_i),
        .instr_en_i    (instr_req_i),
        .instr_addr_i  (instr_addr_i),
        .instr_rdata_o (instr_rdata_o),
        .data_en_i     (ram_en),
        .data_we_i     (ram_we),
        .data_be_i     (ram_be),
        .data_addr_i   (ram_addr),
        .data_wdata_i  (ram_wdata),
        .data_rdata_o  (ram_rdata)
    );

    data_resp_ctrl data_resp_ctrl_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_req_i    (data_req_i),
        .rd_target_i   (rd_target),
        .ram_rdata_i   (ram_rdata),
        .timer_cnt_i   (timer_cnt),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o)
    );

    sim_timer sim_timer_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mask_we_i   (timer_mask_we),
        .cnt_we_i    (timer_cnt_we),
        .wdata_i     (timer_wdata),
        .irq_ack_i   (irq_ack_i),
        .irq_id_i    (irq_id_i),
        .cnt_o       (timer_cnt),
        .irq_timer_o (irq_timer_o)
    );

endmodule

`default_nettype wire

// ==== bench/mm_ram_tb.sv ====
// memory-mapped ram testbench
`timescale 1ns/1ps
`default_nettype none

module mm_ram_tb import mm_pkg::*; ();

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        instr_req_i;
    logic        data_req_i;
    logic        data_we_i;
    logic        irq_ack_i;
    ram_addr_t   instr_addr_i;
    word_t       data_addr_i;
    word_t       data_wdata_i;
    be_t         data_be_i;
    irq_id_t     irq_id_i;

    instr_data_t instr_rdata_o;
    word_t       data_rdata_o;
    word_t       exit_value_o;
    logic        instr_rvalid_o, instr_gnt_o, data_rvalid_o, data_gnt_o;
    logic        irq_timer_o, tests_passed_o, tests_failed_o, exit_valid_o;

    // reference model
    logic [7:0]  model_mem [ram_bytes];
    word_t       m_mask = '0;
    word_t       m_cnt = '0;
    logic        m_irq = 1'b0;
    logic        prev_ireq = 1'b0;
    logic        prev_dreq = 1'b0;
    instr_data_t instr_exp_q [$];
    logic [32:0] data_exp_q [$];

    logic [31:0] lfsr_q = 32'h57d7ea26;
    int          err_count;
    int          test_errs;
    int          check_count;
    int          test_count;

    always #2 clk_i = ~clk_i;

    mm_ram mm_ram_inst (.*);

    // fibonacci lfsr with taps 32 22 2 1
    function automatic word_t take_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t model_word(input word_t a);
        ram_addr_t p;
        p = {a[15:2], 2'b00};
        return {model_mem[p + 3], model_mem[p + 2], model_mem[p + 1], model_mem[p]};
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %0h expected %0h", name, got, exp);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic drive_idle();
        instr_req_i  <= 1'b0;
        instr_addr_i <= '0;
        data_req_i   <= 1'b0;
        data_we_i    <= 1'b0;
        data_addr_i  <= '0;
        data_be_i    <= '0;
        data_wdata_i <= '0;
        irq_ack_i    <= 1'b0;
        irq_id_i     <= '0;
    endtask

    // sample at the falling edge, then step the model over the next rising edge
    task automatic check_cycle();
        instr_data_t fetch;
        word_t       rd;
        logic [32:0] de;
        logic        wr;
        logic        st;
        logic        ex;
        ram_addr_t   p;
        @(negedge clk_i);
        wr = data_req_i && data_we_i;
        st = wr && (data_addr_i == addr_test_status);
        ex = wr && (data_addr_i == addr_exit);
        check_value("instr_gnt_o", 128'(instr_gnt_o), 128'(instr_req_i));
        check_value("data_gnt_o", 128'(data_gnt_o), 128'(data_req_i));
        check_value("instr_rvalid_o", 128'(instr_rvalid_o), 128'(prev_ireq));
        check_value("data_rvalid_o", 128'(data_rvalid_o), 128'(prev_dreq));
        check_value("irq_timer_o", 128'(irq_timer_o), 128'(m_irq));
        if (prev_ireq) begin
            check_value("instr_rdata_o", instr_rdata_o, instr_exp_q.pop_front());
        end
        if (prev_dreq) begin
            de = data_exp_q.pop_front();
            // write responses carry no data
            if (de[32]) begin
                check_value("data_rdata_o", 128'(data_rdata_o), 128'(de[31:0]));
            end
        end
        // status outputs have no delay
        check_value("tests_passed_o", 128'(tests_passed_o),
                    128'(st && (data_wdata_i == test_pass_value)));
        check_value("tests_failed_o", 128'(tests_failed_o),
                    128'(st && (data_wdata_i == test_fail_value)));
        check_value("exit_valid_o", 128'(exit_valid_o), 128'(ex));
        check_value("exit_value_o", 128'(exit_value_o), ex ? 128'(data_wdata_i) : 128'(0));

        // expected responses are taken before this cycle's write lands
        if (instr_req_i) begin
            for (int w = 0; w < 4; w++) begin
                p = instr_addr_i + ram_addr_t'(4 * w);
                fetch[32*w +: 32] = model_word(word_t'(p));
            end
            instr_exp_q.push_back(fetch);
        end
        if (data_req_i) begin
            if (data_addr_i < ram_bytes) begin
                rd = model_word(data_addr_i);
            end else if (data_addr_i == addr_timer_cnt) begin
                rd = m_cnt;
            end else begin
                rd = '0;
            end
            data_exp_q.push_back({!data_we_i, rd});
        end

        if (wr && (data_addr_i < ram_bytes)) begin
            p = {data_addr_i[15:2], 2'b00};
            for (int b = 0; b < 4; b++) begin
                if (data_be_i[b]) model_mem[p + b] = data_wdata_i[8*b +: 8];
            end
        end

        // a timer register write freezes the count
        if (wr && (data_addr_i == addr_timer_mask)) begin
            m_mask = data_wdata_i;
        end else if (wr && (data_addr_i == addr_timer_cnt)) begin
            m_cnt = data_wdata_i;
        end else begin
            if ((m_cnt == 1) && m_mask[timer_irq_id]) m_irq = 1'b1;
            if (irq_ack_i && (irq_id_i == irq_id_t'(timer_irq_id))) m_irq = 1'b0;
            if (m_cnt != 0) m_cnt = m_cnt - 1;
        end
        prev_ireq = instr_req_i;
        prev_dreq = data_req_i;
    endtask

    // one full-word data access
    task automatic access(input logic we, input word_t addr, input word_t wdata);
        @(posedge clk_i);
        drive_idle();
        data_req_i   <= 1'b1;
        data_we_i    <= we;
        data_addr_i  <= addr;
        data_be_i    <= 4'hf;
        data_wdata_i <= wdata;
        check_cycle();
    endtask

    // count reads until the interrupt shows
    task automatic wait_irq(input int limit);
        int i;
        i = 0;
        while ((irq_timer_o !== 1'b1) && (i < limit)) begin
            access(1'b0, addr_timer_cnt, '0);
            i++;
        end
        if (irq_timer_o !== 1'b1) begin
            $display("timer interrupt did not arrive within %0d cycles", limit);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d errors", name, test_errs);
        test_count++;
        test_errs = 0;
    endtask

    initial begin
        ram_addr_t ca;
        word_t     v;
        word_t     irq_bit;
        int        c;
        irq_bit = word_t'(1) << timer_irq_id;
        rst_ni <= 1'b0;
        drive_idle();
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;

        // fill pattern depends on the whole word address
        for (int i = 0; i < ram_bytes / 4; i++) begin
            access(1'b1, word_t'(4 * i), word_t'(i) * 32'h9e37_79b1);
        end
        // handshake on both ports is checked in every cycle from here on
        for (int k = 0; k < 400; k++) begin
            @(posedge clk_i);
            drive_idle();
            instr_req_i  <= 1'(take_bits(1));
            instr_addr_i <= ram_addr_t'(take_bits(16));
            data_req_i   <= (take_bits(3) != 0);
            // mostly a small window so reads hit recent writes
            data_addr_i  <= (take_bits(2) == 0) ? take_bits(16) : (32'h4000 | take_bits(8));
            data_we_i    <= 1'(take_bits(1));
            data_be_i    <= be_t'(take_bits(4));
            data_wdata_i <= take_bits(32);
            check_cycle();
        end
        finish_test("data ram");

        for (int k = 0; k < 300; k++) begin
            @(posedge clk_i);
            drive_idle();
            // every eighth fetch wraps at the top of the ram
            if (k % 8 == 0) begin
                ca = 16'hfff4 | ram_addr_t'(take_bits(4));
            end else begin
                ca = ram_addr_t'(take_bits(16));
            end
            instr_req_i  <= 1'b1;
            instr_addr_i <= ca;
            data_req_i   <= 1'(take_bits(1));
            data_we_i    <= 1'b1;
            data_be_i    <= be_t'(take_bits(4));
            data_wdata_i <= take_bits(32);
            // half the writes land in the line being fetched
            ca = ca + ram_addr_t'(4 * take_bits(2));
            data_addr_i  <= take_bits(1) ? word_t'(ca) : take_bits(16);
            check_cycle();
        end
        finish_test("instr fetch");

        access(1'b1, addr_timer_cnt, 32'h00ff_ffff);
        for (int k = 0; k < 200; k++) begin
            @(posedge clk_i);
            drive_idle();
            // bit 16 keeps the address clear of the ram and every register
            data_req_i   <= 1'b1;
            data_addr_i  <= take_bits(32) | 32'h0001_0000;
            data_we_i    <= 1'(take_bits(1));
            data_be_i    <= be_t'(take_bits(4));
            // the timer enable bit is always set in the write data
            data_wdata_i <= take_bits(32) | irq_bit;
            check_cycle();
        end
        for (int k = 0; k < ram_bytes / 4; k++) begin
            access(1'b0, word_t'(4 * k), '0);
        end
        access(1'b0, addr_timer_cnt, '0);
        // a short count shows whether the mask was touched
        access(1'b1, addr_timer_cnt, 32'd2);
        for (int k = 0; k < 4; k++) begin
            access(1'b0, addr_timer_cnt, '0);
        end
        finish_test("unmapped");

        for (int k = 0; k < 16; k++) begin
            v = take_bits(32);
            case (k % 4)
                0: access(1'b1, addr_test_status, test_pass_value);
                1: access(1'b1, addr_test_status, test_fail_value);
                2: access(1'b1, addr_test_status, v);
                default: access(1'b1, addr_exit, v);
            endcase
        end
        finish_test("test status");

        for (int r = 0; r < 4; r++) begin
            // odd rounds enable the interrupt
            v = take_bits(32);
            access(1'b1, addr_timer_mask, r[0] ? (v | irq_bit) : (v & ~irq_bit));
            c = 2 + int'(take_bits(4));
            access(1'b1, addr_timer_cnt, word_t'(c));
            if (r[0]) begin
                wait_irq(c + 8);
                for (int k = 0; k < 4; k++) begin
                    @(posedge clk_i);
                    drive_idle();
                    irq_ack_i <= 1'b1;
                    // an id with bit 4 set never matches and only the last ack clears
                    if (k == 3) begin
                        irq_id_i <= irq_id_t'(timer_irq_id);
                    end else begin
                        irq_id_i <= irq_id_t'(take_bits(5)) | 5'h10;
                    end
                    check_cycle();
                end
            end
            for (int k = 0; k < c + 4; k++) begin
                access(1'b0, addr_timer_cnt, '0);
            end
        end
        finish_test("timer");

        // last responses come out here
        @(posedge clk_i);
        drive_idle();
        check_cycle();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hw/mm_pkg.sv
hw/dp_ram.sv
hw/data_decoder.sv
hw/data_resp_ctrl.sv
hw/sim_timer.sv
hw/mm_ram.sv
bench/mm_ram_tb.sv
